// File: hw/periph_pkg.sv
// Peripheral bus definitions
package periph_pkg;

    // Bus widths with a meaning of their own
    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  func_sel_t;
    typedef logic [1:0]  irq_t;

    // Access size encoded like the active-low strobes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } size_e;

    // Output function codes for the pin selectors
    localparam func_sel_t FUNC_NONE      = 3'd0;
    localparam func_sel_t FUNC_GPIO      = 3'd1;
    localparam func_sel_t FUNC_UART_TX   = 3'd2;
    localparam func_sel_t FUNC_UART_RX   = 3'd3;
    localparam func_sel_t FUNC_BYTE_REGS = 3'd4;

    // User slots are 64 bytes and simple slots 16 bytes
    localparam logic [3:0] SLOT_GPIO        = 4'd1;
    localparam logic [3:0] SLOT_UART_TX     = 4'd2;
    localparam logic [3:0] SLOT_UART_RX     = 4'd3;
    localparam logic [3:0] SIMPLE_BYTE_REGS = 4'd0;

    // Request to one user peripheral with strobes already gated by its select
    typedef struct packed {
        logic [5:0] offset;
        word_t      wdata;
        logic       wr;
        logic       rd;
    } periph_req_t;

endpackage

// File: hw/periph_bus.sv
// Peripheral bus control
`timescale 1ns/1ns

module periph_bus import periph_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  addr_t       addr,
    input  word_t       wdata,
    input  size_e       write_n,
    input  size_e       read_n,
    input  logic        read_complete,
    output word_t       rdata,
    output logic        data_ready,
    output periph_req_t gpio_req,
    output periph_req_t tx_req,
    output periph_req_t rx_req,
    input  word_t       gpio_rdata,
    input  word_t       tx_rdata,
    input  word_t       rx_rdata,
    output logic [3:0]  simple_offset,
    output byte_t       simple_wdata,
    output logic        regs_wr,
    input  byte_t       regs_rdata
);

    logic        rd_active;
    logic        wr_active;
    logic        req_active;
    logic        last_req;
    logic        hold;
    logic        capture;
    logic        ready_q;
    word_t       rdata_q;
    word_t       mux_rdata;
    logic [15:0] user_sel;
    logic [15:0] simple_sel;

    function automatic periph_req_t make_req(input logic sel, input logic rd_strobe);
        periph_req_t r;
        r.offset = addr[5:0];
        r.wdata  = wdata;
        r.wr     = wr_active & sel;
        r.rd     = rd_strobe & sel;
        return r;
    endfunction

    assign rd_active  = (read_n != SIZE_NONE);
    assign wr_active  = (write_n != SIZE_NONE);
    assign req_active = rd_active | wr_active;

    // One-hot slot decode where bit 10 picks the simple region
    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (addr[10]) begin
            simple_sel[addr[7:4]] = 1'b1;
        end else begin
            user_sel[addr[9:6]] = 1'b1;
        end
    end

    // UART RX sees only the first cycle of a read so valid clears once
    always_comb begin
        gpio_req = make_req(user_sel[SLOT_GPIO], rd_active);
        tx_req   = make_req(user_sel[SLOT_UART_TX], rd_active);
        rx_req   = make_req(user_sel[SLOT_UART_RX], rd_active & ~last_req);
    end

    assign simple_offset = addr[3:0];
    assign simple_wdata  = wdata[7:0];
    assign regs_wr       = wr_active & simple_sel[SIMPLE_BYTE_REGS];

    // Empty slots read zero
    always_comb begin
        mux_rdata = '0;
        if (user_sel[SLOT_GPIO]) begin
            mux_rdata = gpio_rdata;
        end else if (user_sel[SLOT_UART_TX]) begin
            mux_rdata = tx_rdata;
        end else if (user_sel[SLOT_UART_RX]) begin
            mux_rdata = rx_rdata;
        end else if (simple_sel[SIMPLE_BYTE_REGS]) begin
            mux_rdata = {24'h0, regs_rdata};
        end
    end

    assign capture = rd_active & ~hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold     <= 1'b0;
            last_req <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            if (read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            last_req <= req_active;
            // High on the third cycle of a request
            ready_q  <= last_req & req_active;
        end
    end

    // Captured read data is held until the core completes the read
    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= mux_rdata;
        end
    end

    assign rdata      = rdata_q;
    assign data_ready = ready_q;

endmodule

// File: hw/gpio_block.sv
// GPIO and output function select
`timescale 1ns/1ns

module gpio_block import periph_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t req,
    output word_t       rdata,
    input  byte_t       ui_in,
    input  byte_t       tx_out,
    input  byte_t       rx_out,
    input  byte_t       regs_out,
    output byte_t       uo_out
);

    byte_t     gpio_out;
    func_sel_t func_sel [8];
    logic      sel_hit;
    logic [2:0] sel_idx;

    // Selectors sit at 0x20 + 4n
    assign sel_hit = req.offset[5] & (req.offset[1:0] == 2'b00);
    assign sel_idx = req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (req.wr && req.offset == 6'h00) begin
            gpio_out <= req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= FUNC_GPIO;
            end
            // Pins 0 and 1 default to the UART lines
            func_sel[0] <= FUNC_UART_TX;
            func_sel[1] <= FUNC_UART_RX;
        end else if (req.wr && sel_hit) begin
            func_sel[sel_idx] <= req.wdata[2:0];
        end
    end

    always_comb begin
        rdata = '0;
        if (req.offset == 6'h00) begin
            rdata = {24'h0, gpio_out};
        end else if (req.offset == 6'h04) begin
            rdata = {24'h0, ui_in};
        end else if (sel_hit) begin
            rdata = {29'h0, func_sel[sel_idx]};
        end
    end

    // Each pin takes its own bit of the chosen source byte
    always_comb begin
        for (int n = 0; n < 8; n++) begin
            case (func_sel[n])
                FUNC_GPIO:      uo_out[n] = gpio_out[n];
                FUNC_UART_TX:   uo_out[n] = tx_out[n];
                FUNC_UART_RX:   uo_out[n] = rx_out[n];
                FUNC_BYTE_REGS: uo_out[n] = regs_out[n];
                default:        uo_out[n] = 1'b0;
            endcase
        end
    end

endmodule

// File: hw/uart_tx.sv
// UART transmitter
`timescale 1ns/1ns

module uart_tx import periph_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t req,
    output word_t       rdata,
    output byte_t       txd_out,
    output logic        irq
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e         state;
    logic [CNT_W-1:0]  cnt;
    logic [2:0]        bit_idx;
    byte_t             data_q;
    logic              busy;
    logic              load;
    logic              bit_done;
    logic              txd;

    assign busy     = (state != TX_IDLE);
    assign load     = req.wr && (req.offset == 6'h00) && !busy;
    assign bit_done = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (load) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    bit_idx <= '0;
                    if (bit_done) begin
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Line idles high and data goes out LSB first
    assign txd = (state == TX_START) ? 1'b0 :
                 (state == TX_DATA)  ? data_q[bit_idx] : 1'b1;

    assign rdata   = (req.offset == 6'h00) ? {24'h0, data_q} :
                     (req.offset == 6'h04) ? {31'h0, busy}   : '0;
    assign txd_out = {8{txd}};
    assign irq     = ~busy;

endmodule

// File: hw/uart_rx.sv
// UART receiver
`timescale 1ns/1ns

module uart_rx import periph_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  periph_req_t req,
    output word_t       rdata,
    input  logic        rxd,
    output byte_t       rts_out,
    output logic        irq
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    byte_t            data_q;
    logic             valid;
    logic             store;
    logic             half_bit;
    logic             full_bit;

    assign rx_s     = rx_sync[1];
    assign half_bit = (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign full_bit = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign store    = (state == RX_STOP) && full_bit && rx_s;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rxd};
            cnt     <= full_bit ? '0 : cnt + 1'b1;
            // A first-cycle read of the data register clears valid
            if (req.rd && req.offset == 6'h00) begin
                valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at mid-bit, then count from there
                    if (half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        valid <= valid | rx_s;
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && full_bit) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (store) begin
            data_q <= shift_q;
        end
    end

    assign rdata   = (req.offset == 6'h00) ? {24'h0, data_q} :
                     (req.offset == 6'h04) ? {31'h0, valid}  : '0;
    assign rts_out = {8{valid}};
    assign irq     = valid;

endmodule

// File: hw/byte_regs.sv
// Simple byte register peripheral
`timescale 1ns/1ns

module byte_regs import periph_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] offset,
    input  byte_t      wdata,
    input  logic       wr,
    output byte_t      rdata,
    output byte_t      out_byte
);

    byte_t regs [4];
    logic  in_range;

    // Only offsets 0 to 3 hold registers
    assign in_range = (offset[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr && in_range) begin
            regs[offset[1:0]] <= wdata;
        end
    end

    assign rdata    = in_range ? regs[offset[1:0]] : '0;
    assign out_byte = regs[0];

endmodule

// File: hw/periph_top.sv
// Peripheral subsystem top
`timescale 1ns/1ns

module periph_top import periph_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t addr,
    input  word_t wdata,
    input  size_e write_n,
    input  size_e read_n,
    input  logic  read_complete,
    output word_t rdata,
    output logic  data_ready,
    input  byte_t ui_in,
    output byte_t uo_out,
    output irq_t  interrupts
);

    periph_req_t gpio_req;
    periph_req_t tx_req;
    periph_req_t rx_req;
    word_t       gpio_rdata;
    word_t       tx_rdata;
    word_t       rx_rdata;
    logic [3:0]  simple_offset;
    byte_t       simple_wdata;
    logic        regs_wr;
    byte_t       regs_rdata;
    byte_t       tx_out;
    byte_t       rx_out;
    byte_t       regs_out;
    logic        tx_irq;
    logic        rx_irq;

    periph_bus u_bus (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .write_n(write_n), .read_n(read_n), .read_complete(read_complete),
        .rdata(rdata), .data_ready(data_ready),
        .gpio_req(gpio_req), .tx_req(tx_req), .rx_req(rx_req),
        .gpio_rdata(gpio_rdata), .tx_rdata(tx_rdata), .rx_rdata(rx_rdata),
        .simple_offset(simple_offset), .simple_wdata(simple_wdata),
        .regs_wr(regs_wr), .regs_rdata(regs_rdata)
    );

    gpio_block u_gpio (
        .clk(clk), .rst_n(rst_n), .req(gpio_req), .rdata(gpio_rdata), .ui_in(ui_in),
        .tx_out(tx_out), .rx_out(rx_out), .regs_out(regs_out), .uo_out(uo_out)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk(clk), .rst_n(rst_n), .req(tx_req), .rdata(tx_rdata),
        .txd_out(tx_out), .irq(tx_irq)
    );

    // RX line comes in on pin 7
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk(clk), .rst_n(rst_n), .req(rx_req), .rdata(rx_rdata),
        .rxd(ui_in[7]), .rts_out(rx_out), .irq(rx_irq)
    );

    byte_regs u_byte_regs (
        .clk(clk), .rst_n(rst_n), .offset(simple_offset), .wdata(simple_wdata),
        .wr(regs_wr), .rdata(regs_rdata), .out_byte(regs_out)
    );

    assign interrupts = {rx_irq, tx_irq};

endmodule

// File: dv/periph_tb.sv
// Peripheral bus testbench
`timescale 1ns/1ns

module periph_tb import periph_pkg::*; ();

    localparam int CLKS_PER_BIT = 8;
    // Two UART frames take about 160 cycles and the bus tests stay under 1000
    localparam int MAX_CYCLES   = 6000;

    // User slots sit at n * 64 and simple slots at 0x400 + n * 16
    localparam addr_t ADDR_GPIO         = 11'h040;
    localparam addr_t ADDR_TX           = 11'h080;
    localparam addr_t ADDR_RX           = 11'h0C0;
    localparam addr_t ADDR_EMPTY_USER   = 11'h140;
    localparam addr_t ADDR_REGS         = 11'h400;
    localparam addr_t ADDR_EMPTY_SIMPLE = 11'h430;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t wdata;
    size_e write_n;
    size_e read_n;
    logic  read_complete;
    word_t rdata;
    logic  data_ready;
    byte_t ui_in;
    byte_t uo_out;
    irq_t  interrupts;

    int    errors;
    int    checks;
    int    cycle_count;
    int    ready_cycles;
    byte_t lfsr_state;

    periph_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .write_n(write_n), .read_n(read_n), .read_complete(read_complete),
        .rdata(rdata), .data_ready(data_ready),
        .ui_in(ui_in), .uo_out(uo_out), .interrupts(interrupts)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1
    function automatic byte_t lfsr_next(input byte_t s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // One LFSR step per bit with the LSB taken first
    task automatic rand_byte(output byte_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Holds the request until data_ready, counting request cycles
    task automatic bus_access(input addr_t a, input word_t d, input size_e wsize,
                              input size_e rsize, output word_t data);
        int cycles;
        @(posedge clk);
        addr    <= a;
        wdata   <= d;
        write_n <= wsize;
        read_n  <= rsize;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (data_ready !== 1'b1);
        data = rdata;
        ready_cycles = cycles;
        @(posedge clk);
        write_n <= SIZE_NONE;
        read_n  <= SIZE_NONE;
        if (rsize != SIZE_NONE) begin
            read_complete <= 1'b1;
            @(posedge clk);
            read_complete <= 1'b0;
        end
    endtask

    task automatic bus_write(input addr_t a, input word_t d, input size_e size);
        word_t unused;
        bus_access(a, d, size, SIZE_NONE, unused);
    endtask

    task automatic bus_read(input addr_t a, output word_t data);
        bus_access(a, '0, SIZE_NONE, SIZE_WORD, data);
    endtask

    // Drives one 8N1 frame on the RX pin
    task automatic send_frame(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            ui_in[7] <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Samples pin 0 at mid-bit through a whole TX frame
    task automatic watch_tx_frame(input byte_t expected);
        @(negedge clk);
        while (uo_out[0] !== 1'b0) begin
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        check_value("tx start bit", 0, word_t'(uo_out[0]));
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value($sformatf("tx data bit %0d", i), word_t'(expected[i]),
                        word_t'(uo_out[0]));
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("tx stop bit", 1, word_t'(uo_out[0]));
    endtask

    task automatic reset_defaults();
        word_t d;
        @(negedge clk);
        check_value("reset uo_out", 32'h01, word_t'(uo_out));
        check_value("reset interrupts", 32'h1, word_t'(interrupts));
        // Ready must be low for two request cycles and high in the third
        bus_read(ADDR_GPIO, d);
        check_value("reset gpio out", 32'h0, d);
        check_value("read ready cycle", 3, ready_cycles);
        bus_write(ADDR_GPIO, 32'h0, SIZE_WORD);
        check_value("write ready cycle", 3, ready_cycles);
    endtask

    task automatic gpio_access();
        byte_t b;
        word_t d;
        rand_byte(b);
        bus_write(ADDR_GPIO, {4{b}}, SIZE_WORD);
        bus_read(ADDR_GPIO, d);
        check_value("gpio out readback", {24'h0, b}, d);
        // Bit 7 stays high so the RX line remains idle
        @(posedge clk);
        ui_in <= 8'hA5;
        bus_read(ADDR_GPIO + 11'h004, d);
        check_value("gpio input readback", 32'hA5, d);
        @(negedge clk);
        check_value("gpio pins", {24'h0, b[7:2], 2'b01}, word_t'(uo_out));
    endtask

    task automatic pin_function_select();
        byte_t r;
        word_t d;
        for (int n = 2; n < 8; n++) begin
            bus_write(ADDR_GPIO + addr_t'(32 + 4 * n), {29'h0, FUNC_BYTE_REGS}, SIZE_BYTE);
        end
        rand_byte(r);
        bus_write(ADDR_REGS, {24'h0, r}, SIZE_BYTE);
        for (int n = 2; n < 8; n++) begin
            bus_read(ADDR_GPIO + addr_t'(32 + 4 * n), d);
            check_value($sformatf("func sel %0d", n), 32'd4, d);
        end
        bus_read(ADDR_REGS, d);
        check_value("byte reg 0 readback", {24'h0, r}, d);
        @(negedge clk);
        check_value("pins from byte regs", {24'h0, r[7:2], 2'b01}, word_t'(uo_out));
        // Pin 7 switched off
        bus_write(ADDR_GPIO + 11'h03C, {29'h0, FUNC_NONE}, SIZE_BYTE);
        bus_read(ADDR_GPIO + 11'h03C, d);
        check_value("func sel 7 none", 32'd0, d);
        @(negedge clk);
        check_value("pin 7 off", {24'h0, 1'b0, r[6:2], 2'b01}, word_t'(uo_out));
    endtask

    task automatic uart_tx_frame();
        byte_t b;
        word_t d;
        rand_byte(b);
        fork
            watch_tx_frame(b);
            begin
                bus_write(ADDR_TX, {24'h0, b}, SIZE_BYTE);
                bus_read(ADDR_TX + 11'h004, d);
                check_value("tx busy", 1, d);
                @(negedge clk);
                check_value("tx irq while busy", 0, word_t'(interrupts[0]));
            end
        join
        // The idle interrupt marks the end of the frame
        @(negedge clk);
        while (interrupts[0] !== 1'b1) begin
            @(negedge clk);
        end
        bus_read(ADDR_TX + 11'h004, d);
        check_value("tx idle", 0, d);
        bus_read(ADDR_TX, d);
        check_value("tx data readback", {24'h0, b}, d);
    endtask

    task automatic uart_rx_frame();
        byte_t b;
        word_t d;
        rand_byte(b);
        send_frame(b);
        @(negedge clk);
        while (interrupts[1] !== 1'b1) begin
            @(negedge clk);
        end
        check_value("rx rts pin", 1, word_t'(uo_out[1]));
        bus_read(ADDR_RX + 11'h004, d);
        check_value("rx valid", 1, d);
        bus_read(ADDR_RX, d);
        check_value("rx data", {24'h0, b}, d);
        @(negedge clk);
        check_value("rx irq cleared", 0, word_t'(interrupts[1]));
        check_value("rx rts cleared", 0, word_t'(uo_out[1]));
        bus_read(ADDR_RX + 11'h004, d);
        check_value("rx valid cleared", 0, d);
    endtask

    task automatic empty_and_simple_slots();
        byte_t vals [4];
        byte_t b;
        word_t d;
        for (int i = 0; i < 4; i++) begin
            rand_byte(b);
            vals[i] = b;
            bus_write(ADDR_REGS + addr_t'(i), {8'hFF, 16'h0, b},
                      (i % 2 == 1) ? SIZE_HALF : SIZE_BYTE);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(ADDR_REGS + addr_t'(i), d);
            check_value($sformatf("byte reg %0d", i), {24'h0, vals[i]}, d);
        end
        for (int i = 4; i < 16; i++) begin
            bus_read(ADDR_REGS + addr_t'(i), d);
            check_value($sformatf("byte regs offset %0d", i), 32'h0, d);
        end
        bus_write(ADDR_EMPTY_USER, 32'hDEAD_BEEF, SIZE_WORD);
        check_value("empty user write ready", 3, ready_cycles);
        bus_read(ADDR_EMPTY_USER, d);
        check_value("empty user read", 32'h0, d);
        check_value("empty user read ready", 3, ready_cycles);
        bus_read(ADDR_EMPTY_SIMPLE, d);
        check_value("empty simple read", 32'h0, d);
        check_value("empty simple read ready", 3, ready_cycles);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        addr          = '0;
        wdata         = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        ui_in         = 8'h80;
        errors        = 0;
        checks        = 0;
        cycle_count   = 0;
        ready_cycles  = 0;
        lfsr_state    = 8'd58;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        reset_defaults();
        gpio_access();
        pin_function_select();
        uart_tx_frame();
        uart_rx_frame();
        empty_and_simple_slots();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hw/periph_pkg.sv
hw/periph_bus.sv
hw/gpio_block.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/byte_regs.sv
hw/periph_top.sv
dv/periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the peripheral bus simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module periph_tb -o periph_sim

./obj_dir/periph_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
